/* hw/isa_pkg.sv */
package isa_pkg;

    // ************************************************************************
    // data-processing instruction word
    // ************************************************************************

    typedef logic [31:0] instr_t;

    localparam int COND_MSB  = 31;
    localparam int CLASS_LSB = 26;          // bits 27:26.
    localparam int I_BIT     = 25;
    localparam int OPC_LSB   = 21;
    localparam int S_BIT     = 20;
    localparam int RN_LSB    = 16;
    localparam int RD_LSB    = 12;
    localparam int ROT_LSB   = 8;
    localparam int RM_LSB    = 0;
    localparam int IMM8_LSB  = 0;

    localparam logic [1:0] DP_CLASS = 2'b00;

    // arm opcode values.
    typedef enum logic [3:0] {
        OP_AND = 4'b0000,
        OP_EOR = 4'b0001,
        OP_SUB = 4'b0010,
        OP_ADD = 4'b0100,
        OP_CMP = 4'b1010,
        OP_ORR = 4'b1100,
        OP_MOV = 4'b1101
    } alu_op_e;

    typedef enum logic [3:0] {
        COND_EQ, COND_NE, COND_CS, COND_CC,
        COND_MI, COND_PL, COND_VS, COND_VC,
        COND_HI, COND_LS, COND_GE, COND_LT,
        COND_GT, COND_LE, COND_AL, COND_NV  // nv never passes.
    } cond_e;

endpackage

/* hw/core_pkg.sv */
package core_pkg;

    typedef logic [1:0]  thread_t;
    typedef logic [3:0]  reg_idx_t;
    typedef logic [31:0] word_t;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

    // ************************************************************************
    // stage records
    // ************************************************************************

    typedef struct packed {
        logic             valid;
        logic             supported;        // dp class, listed opcode.
        thread_t          thread;
        isa_pkg::alu_op_e op;
        isa_pkg::cond_e   cond;
        logic             set_flags;
        reg_idx_t         rn;
        reg_idx_t         rd;
        reg_idx_t         rm;
        logic             use_imm;
        word_t            imm;              // already rotated.
    } issue_t;

    typedef struct packed {
        logic     valid;
        logic     executed;
        logic     write;
        logic     flag_write;
        thread_t  thread;
        reg_idx_t rd;
        word_t    result;                   // zero when not executed.
        flags_t   flags;                    // flags the thread holds afterwards.
    } exec_t;

    typedef struct packed {
        thread_t  thread;
        reg_idx_t rd;
        logic     executed;
        logic     write;
        word_t    result;
        flags_t   flags;
    } retire_t;

endpackage

/* hw/dp_decode.sv */
`timescale 1ns/1ps
module dp_decode #(
    parameter int N_THREADS = 4
) (
    input  logic              clk,
    input  logic              rstb,
    input  logic              instr_valid,
    input  isa_pkg::instr_t   instr,
    input  core_pkg::thread_t thread_id,
    output core_pkg::issue_t  issue
);
    import isa_pkg::*;
    import core_pkg::*;

    instr_t      instr_q;
    thread_t     thread_q;
    logic        in_valid_q;
    alu_op_e     opc;
    logic [7:0]  imm8;
    logic [4:0]  shamt;
    logic [63:0] imm_dbl;
    issue_t      issue_d;
    issue_t      issue_q;
    logic        valid_q;

    // ************************************************************************
    // input sample
    // ************************************************************************

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            instr_q  <= instr;
            thread_q <= thread_id;
        end
    end

    // ************************************************************************
    // field split and immediate
    // ************************************************************************

    always_comb begin
        opc     = alu_op_e'(instr_q[OPC_LSB +: 4]);
        imm8    = instr_q[IMM8_LSB +: 8];
        shamt   = {instr_q[ROT_LSB +: 4], 1'b0};      // twice the rotate field.
        imm_dbl = {24'b0, imm8, 24'b0, imm8} >> shamt; // low half is the ror.

        issue_d.valid     = in_valid_q;
        issue_d.supported = 1'b0;
        if (instr_q[CLASS_LSB +: 2] == DP_CLASS) begin
            case (opc)
                OP_AND, OP_EOR, OP_SUB, OP_ADD,
                OP_CMP, OP_ORR, OP_MOV: issue_d.supported = 1'b1;
                default:                issue_d.supported = 1'b0;
            endcase
        end
        issue_d.thread    = thread_q;
        issue_d.op        = opc;
        issue_d.cond      = cond_e'(instr_q[COND_MSB -: 4]);
        issue_d.set_flags = instr_q[S_BIT];
        issue_d.rn        = instr_q[RN_LSB +: 4];
        issue_d.rd        = instr_q[RD_LSB +: 4];
        issue_d.rm        = instr_q[RM_LSB +: 4];  // shift field ignored.
        issue_d.use_imm   = instr_q[I_BIT];
        issue_d.imm       = imm_dbl[31:0];
    end

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            in_valid_q <= 1'b0;
            valid_q    <= 1'b0;
        end else begin
            in_valid_q <= instr_valid;
            valid_q    <= in_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_q) begin
            issue_q <= issue_d;
        end
    end

    always_comb begin
        issue       = issue_q;
        issue.valid = valid_q;
    end

    a_thread_range: assert property (@(posedge clk) disable iff (!rstb)
        issue.valid |-> (issue.thread < N_THREADS));

endmodule

/* hw/dp_execute.sv */
`timescale 1ns/1ps
module dp_execute (
    input  logic               clk,
    input  logic               rstb,
    input  core_pkg::issue_t   issue,
    input  core_pkg::word_t    rn_data,
    input  core_pkg::word_t    rm_data,
    input  core_pkg::flags_t   cur_flags,
    output core_pkg::thread_t  rd_thread,
    output core_pkg::reg_idx_t rn,
    output core_pkg::reg_idx_t rm,
    output core_pkg::exec_t    exec
);
    import isa_pkg::*;
    import core_pkg::*;

    word_t       op_b;
    logic [32:0] add_full;
    logic [32:0] sub_full;
    word_t       alu_res;
    flags_t      alu_flags;
    logic        executed;
    logic        is_cmp;
    logic        flag_upd;
    exec_t       exec_d;
    exec_t       exec_q;
    logic        exec_valid_q;

    function automatic logic cond_pass(cond_e cond, flags_t f);
        logic pass;
        case (cond)
            COND_EQ: pass = f.z;
            COND_NE: pass = !f.z;
            COND_CS: pass = f.c;
            COND_CC: pass = !f.c;
            COND_MI: pass = f.n;
            COND_PL: pass = !f.n;
            COND_VS: pass = f.v;
            COND_VC: pass = !f.v;
            COND_HI: pass = f.c && !f.z;
            COND_LS: pass = !f.c || f.z;
            COND_GE: pass = (f.n == f.v);
            COND_LT: pass = (f.n != f.v);
            COND_GT: pass = !f.z && (f.n == f.v);
            COND_LE: pass = f.z || (f.n != f.v);
            COND_AL: pass = 1'b1;
            default: pass = 1'b0;
        endcase
        return pass;
    endfunction

    assign rd_thread = issue.thread;
    assign rn        = issue.rn;
    assign rm        = issue.rm;

    // ************************************************************************
    // alu
    // ************************************************************************

    always_comb begin
        op_b     = issue.use_imm ? issue.imm : rm_data;
        add_full = {1'b0, rn_data} + {1'b0, op_b};
        sub_full = {1'b0, rn_data} + {1'b0, ~op_b} + 33'd1; // carry set on no borrow.
        alu_res     = '0;
        alu_flags.c = 1'b0;
        alu_flags.v = 1'b0;
        case (issue.op)
            OP_ADD: begin
                alu_res     = add_full[31:0];
                alu_flags.c = add_full[32];
                alu_flags.v = (rn_data[31] == op_b[31]) && (alu_res[31] != rn_data[31]);
            end
            OP_SUB, OP_CMP: begin
                alu_res     = sub_full[31:0];
                alu_flags.c = sub_full[32];
                alu_flags.v = (rn_data[31] != op_b[31]) && (alu_res[31] != rn_data[31]);
            end
            OP_AND:  alu_res = rn_data & op_b;
            OP_EOR:  alu_res = rn_data ^ op_b;
            OP_ORR:  alu_res = rn_data | op_b;
            OP_MOV:  alu_res = op_b;
            default: alu_res = '0;
        endcase
        alu_flags.n = alu_res[31];
        alu_flags.z = (alu_res == '0);
    end

    always_comb begin
        executed = issue.supported && cond_pass(issue.cond, cur_flags);
        is_cmp   = (issue.op == OP_CMP);
        flag_upd = executed && (is_cmp || issue.set_flags);

        exec_d.valid      = issue.valid;
        exec_d.executed   = executed;
        exec_d.write      = executed && !is_cmp;
        exec_d.flag_write = flag_upd;
        exec_d.thread     = issue.thread;
        exec_d.rd         = issue.rd;
        exec_d.result     = executed ? alu_res : '0;
        exec_d.flags      = flag_upd ? alu_flags : cur_flags;
    end

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            exec_valid_q <= 1'b0;
        end else begin
            exec_valid_q <= issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue.valid) begin
            exec_q <= exec_d;
        end
    end

    always_comb begin
        exec       = exec_q;
        exec.valid = exec_valid_q;
    end

    a_write_executed: assert property (@(posedge clk) disable iff (!rstb)
        exec.valid && exec.write |-> exec.executed);

endmodule

/* hw/thread_state.sv */
`timescale 1ns/1ps
module thread_state #(
    parameter int N_THREADS = 4
) (
    input  logic               clk,
    input  logic               rstb,
    input  core_pkg::thread_t  rd_thread,
    input  core_pkg::reg_idx_t rn,
    input  core_pkg::reg_idx_t rm,
    input  core_pkg::exec_t    exec,
    output core_pkg::word_t    rn_data,
    output core_pkg::word_t    rm_data,
    output core_pkg::flags_t   cur_flags,
    output logic               retire_valid,
    output core_pkg::retire_t  retire
);
    import core_pkg::*;

    localparam int N_REGS = 16;

    word_t  regs [N_THREADS][N_REGS];
    flags_t flags_q [N_THREADS];
    logic   same_thread;
    logic   rn_hit;
    logic   rm_hit;
    logic   flag_hit;

    // ************************************************************************
    // reads with bypass from the write in flight
    // ************************************************************************

    assign same_thread = exec.valid && (exec.thread == rd_thread);
    assign rn_hit      = same_thread && exec.write && (exec.rd == rn);
    assign rm_hit      = same_thread && exec.write && (exec.rd == rm);
    assign flag_hit    = same_thread && exec.flag_write;

    assign rn_data   = rn_hit ? exec.result : regs[rd_thread][rn];
    assign rm_data   = rm_hit ? exec.result : regs[rd_thread][rm];
    assign cur_flags = flag_hit ? exec.flags : flags_q[rd_thread];

    // ************************************************************************
    // state update
    // ************************************************************************

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            for (int t = 0; t < N_THREADS; t++) begin
                for (int r = 0; r < N_REGS; r++) begin
                    regs[t][r] <= '0;
                end
                flags_q[t] <= '0;
            end
        end else if (exec.valid) begin
            if (exec.write) begin
                regs[exec.thread][exec.rd] <= exec.result;
            end
            if (exec.flag_write) begin
                flags_q[exec.thread] <= exec.flags;
            end
        end
    end

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= exec.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (exec.valid) begin
            retire <= '{thread:   exec.thread,
                        rd:       exec.rd,
                        executed: exec.executed,
                        write:    exec.write,
                        result:   exec.result,
                        flags:    exec.flags};  // new or unchanged flags.
        end
    end

    a_flag_executed: assert property (@(posedge clk) disable iff (!rstb)
        exec.valid && exec.flag_write |-> exec.executed);

endmodule

/* hw/dp_core.sv */
`timescale 1ns/1ps
module dp_core #(
    parameter int N_THREADS = 4
) (
    input  logic              clk,
    input  logic              rstb,
    input  logic              instr_valid,
    input  isa_pkg::instr_t   instr,
    input  core_pkg::thread_t thread_id,
    output logic              retire_valid,
    output core_pkg::retire_t retire
);
    import core_pkg::*;

    issue_t   issue;
    exec_t    exec;
    thread_t  rd_thread;
    reg_idx_t rn;
    reg_idx_t rm;
    word_t    rn_data;
    word_t    rm_data;
    flags_t   cur_flags;

    dp_decode #(
        .N_THREADS (N_THREADS)
    ) u_decode (
        .clk         (clk),
        .rstb        (rstb),
        .instr_valid (instr_valid),
        .instr       (instr),
        .thread_id   (thread_id),
        .issue       (issue)
    );

    dp_execute u_execute (
        .clk       (clk),
        .rstb      (rstb),
        .issue     (issue),
        .rn_data   (rn_data),
        .rm_data   (rm_data),
        .cur_flags (cur_flags),
        .rd_thread (rd_thread),
        .rn        (rn),
        .rm        (rm),
        .exec      (exec)
    );

    thread_state #(
        .N_THREADS (N_THREADS)
    ) u_state (
        .clk          (clk),
        .rstb         (rstb),
        .rd_thread    (rd_thread),
        .rn           (rn),
        .rm           (rm),
        .exec         (exec),
        .rn_data      (rn_data),
        .rm_data      (rm_data),
        .cur_flags    (cur_flags),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

/* verification/dp_model.svh */
`ifndef DP_MODEL_SVH
`define DP_MODEL_SVH

word_t  model_regs  [N_THREADS][16];
flags_t model_flags [N_THREADS];

task automatic reset_model();
    for (int t = 0; t < N_THREADS; t++) begin
        for (int r = 0; r < 16; r++) begin
            model_regs[t][r] = '0;
        end
        model_flags[t] = '0;
    end
endtask

// low bit of the code inverts the test of the pair.
function automatic logic cond_holds(logic [3:0] code, flags_t f);
    logic base;
    case (code[3:1])
        3'd0:    base = f.z;
        3'd1:    base = f.c;
        3'd2:    base = f.n;
        3'd3:    base = f.v;
        3'd4:    base = f.c & ~f.z;
        3'd5:    base = (f.n == f.v);
        3'd6:    base = ~f.z & (f.n == f.v);
        default: base = 1'b1;
    endcase
    return (code == 4'b1111) ? 1'b0 : (base ^ code[0]);
endfunction

function automatic word_t rotated_imm(logic [3:0] rot, logic [7:0] imm8);
    int    sh;
    word_t w;
    sh = 2 * rot;
    w  = {24'b0, imm8};
    return (w >> sh) | (w << (32 - sh));
endfunction

task automatic model_issue(input instr_t ins, input thread_t th, output retire_t exp);
    logic [3:0]  opc;
    logic        supported;
    word_t       a;
    word_t       b;
    word_t       res;
    logic [32:0] wide;
    longint      sres;
    flags_t      old_f;
    flags_t      new_f;
    logic        executed;
    logic        flag_wr;

    opc       = ins[OPC_LSB +: 4];
    supported = (ins[CLASS_LSB +: 2] == DP_CLASS) &&
                (opc inside {OP_AND, OP_EOR, OP_SUB, OP_ADD, OP_CMP, OP_ORR, OP_MOV});
    a = model_regs[th][ins[RN_LSB +: 4]];
    b = ins[I_BIT] ? rotated_imm(ins[ROT_LSB +: 4], ins[IMM8_LSB +: 8])
                   : model_regs[th][ins[RM_LSB +: 4]];
    new_f = '0;
    case (opc)
        OP_ADD: begin
            wide    = {1'b0, a} + {1'b0, b};
            res     = wide[31:0];
            new_f.c = wide[32];
            sres    = longint'($signed(a)) + longint'($signed(b));
            new_f.v = (sres != longint'($signed(res)));
        end
        OP_SUB, OP_CMP: begin
            res     = a - b;
            new_f.c = (a >= b);                 // no borrow.
            sres    = longint'($signed(a)) - longint'($signed(b));
            new_f.v = (sres != longint'($signed(res)));
        end
        OP_AND:  res = a & b;
        OP_EOR:  res = a ^ b;
        OP_ORR:  res = a | b;
        OP_MOV:  res = b;
        default: res = '0;
    endcase
    new_f.n = res[31];
    new_f.z = (res == '0);

    old_f    = model_flags[th];
    executed = supported && cond_holds(ins[COND_MSB -: 4], old_f);
    flag_wr  = executed && ((opc == OP_CMP) || ins[S_BIT]);

    exp.thread   = th;
    exp.rd       = ins[RD_LSB +: 4];
    exp.executed = executed;
    exp.write    = executed && (opc != OP_CMP);
    exp.result   = executed ? res : '0;
    exp.flags    = flag_wr ? new_f : old_f;

    if (exp.write) begin
        model_regs[th][exp.rd] = res;
    end
    if (flag_wr) begin
        model_flags[th] = new_f;
    end
endtask

`endif

/* verification/dp_core_tb.sv */
`timescale 1ns/1ps
module dp_core_tb;
    import isa_pkg::*;
    import core_pkg::*;

    localparam int N_THREADS    = 4;
    localparam int RESET_CYCLES = 10;
    localparam int STIM_CYCLES  = 2000;
    localparam int LATENCY      = 3;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + STIM_CYCLES + LATENCY + 87; // 2100.

    localparam logic [3:0] LISTED [7] = '{OP_AND, OP_EOR, OP_SUB, OP_ADD,
                                          OP_CMP, OP_ORR, OP_MOV};
    localparam logic [3:0] UNLISTED [9] = '{4'd3, 4'd5, 4'd6, 4'd7, 4'd8,
                                            4'd9, 4'd11, 4'd14, 4'd15};

    logic     clk;
    logic     rstb;
    logic     instr_valid;
    instr_t   instr;
    thread_t  thread_id;
    logic     retire_valid;
    retire_t  retire;

    retire_t  exp_q [$];
    int       due_q [$];
    int       cycle = 0;
    int       n_retired = 0;
    thread_t  last_thread;

    `include "dp_model.svh"

    dp_core #(
        .N_THREADS (N_THREADS)
    ) UUT (
        .clk          (clk),
        .rstb         (rstb),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .thread_id    (thread_id),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // ************************************************************************
    // failure reporting and compares
    // ************************************************************************

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic compare_word(string name, word_t exp, word_t act);
        if (exp !== act) begin
            fail_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic compare_flags(string name, flags_t exp, flags_t act);
        if (exp !== act) begin
            fail_run($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic compare_bit(string name, logic exp, logic act);
        if (exp !== act) begin
            fail_run($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic compare_idx(string name, reg_idx_t exp, reg_idx_t act);
        if (exp !== act) begin
            fail_run($sformatf("Mismatch %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_retire();
        retire_t exp;
        int      due;
        string   name;
        if (retire_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                fail_run($sformatf("core retired at cycle %0d with nothing in flight", cycle));
            end else begin
                exp  = exp_q.pop_front();
                due  = due_q.pop_front();
                name = $sformatf("instr %0d", n_retired);
                if (cycle != due) begin
                    fail_run($sformatf("Mismatch %s latency: expected cycle %0d, actual cycle %0d",
                                       name, due, cycle));
                end
                compare_idx({name, " thread"}, reg_idx_t'(exp.thread), reg_idx_t'(retire.thread));
                compare_idx({name, " rd"}, exp.rd, retire.rd);
                compare_bit({name, " executed"}, exp.executed, retire.executed);
                compare_bit({name, " write"}, exp.write, retire.write);
                compare_word({name, " result"}, exp.result, retire.result);
                compare_flags({name, " flags"}, exp.flags, retire.flags);
                n_retired++;
            end
        end
    endtask

    // ************************************************************************
    // stimulus
    // ************************************************************************

    function automatic reg_idx_t pick_reg();
        return ($urandom_range(0, 1) != 0) ? reg_idx_t'($urandom_range(0, 3))
                                           : reg_idx_t'($urandom_range(0, 15));
    endfunction

    function automatic thread_t pick_thread();
        if ($urandom_range(0, 1) == 0) begin
            last_thread = thread_t'($urandom_range(0, N_THREADS - 1));
        end
        return last_thread;                     // repeats favour bypass hits.
    endfunction

    function automatic instr_t make_instr();
        instr_t ins;
        int     pick;
        pick = $urandom_range(0, 99);
        ins  = $urandom();
        ins[COND_MSB -: 4] = ($urandom_range(0, 1) != 0) ? 4'b1110
                                                         : 4'($urandom_range(0, 15));
        if (pick < 90) begin
            ins[CLASS_LSB +: 2] = DP_CLASS;
            ins[OPC_LSB +: 4]   = LISTED[$urandom_range(0, 6)];
        end else if (pick < 95) begin
            ins[CLASS_LSB +: 2] = 2'($urandom_range(1, 3));
        end else begin
            ins[CLASS_LSB +: 2] = DP_CLASS;
            ins[OPC_LSB +: 4]   = UNLISTED[$urandom_range(0, 8)];
        end
        ins[RN_LSB +: 4] = pick_reg();
        ins[RD_LSB +: 4] = pick_reg();
        if (!ins[I_BIT]) begin
            ins[11:4]        = '0;              // unshifted rm.
            ins[RM_LSB +: 4] = pick_reg();
        end
        return ins;
    endfunction

    task automatic drive_cycle();
        instr_t  ins;
        thread_t th;
        retire_t exp;
        if ($urandom_range(0, 99) < 75) begin
            th  = pick_thread();
            ins = make_instr();
            model_issue(ins, th, exp);
            exp_q.push_back(exp);
            due_q.push_back(cycle + LATENCY + 1);
            instr_valid = 1'b1;
            instr       = ins;
            thread_id   = th;
        end else begin
            instr_valid = 1'b0;
            instr       = $urandom();
            thread_id   = thread_t'($urandom_range(0, N_THREADS - 1));
        end
    endtask

    initial begin
        void'($urandom(32'h6e4d_64c5));
        rstb        = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        thread_id   = '0;
        last_thread = '0;
        reset_model();

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_retire();
        end
        rstb = 1'b1;

        repeat (STIM_CYCLES) begin
            @(negedge clk);
            check_retire();
            drive_cycle();
        end

        while (exp_q.size() != 0 && cycle < TIMEOUT_CYCLES) begin
            @(negedge clk);
            check_retire();
            instr_valid = 1'b0;
        end

        if (exp_q.size() == 0) begin
            $display("test passed");
            $finish;
        end else begin
            $display("core stopped retiring with %0d instructions outstanding", exp_q.size());
            $display("test failed");
            $fatal(1);
        end
    end

endmodule

/* src.f */
+incdir+verification
hw/isa_pkg.sv
hw/core_pkg.sv
hw/dp_decode.sv
hw/dp_execute.sv
hw/thread_state.sv
hw/dp_core.sv
verification/dp_core_tb.sv
